// File: Bender.yml
package:
  name: l2_mem_read

sources:
  - files:
      - l2_mem_pkg.sv
      - write_buffer.sv
      - return_buffer.sv
      - read_arbiter.sv
      - l2_mem_read_top.sv
  - target: simulation
    files:
      - tb_mem_model.sv
      - tb_l2_mem_read.sv

// File: filelist.f
l2_mem_pkg.sv
write_buffer.sv
return_buffer.sv
read_arbiter.sv
l2_mem_read_top.sv
tb_mem_model.sv
tb_l2_mem_read.sv

// File: l2_mem_pkg.sv
/* line width is fixed at four 32-bit words
   addresses are line aligned with the low 4 bits zero */
`default_nettype none

package l2_mem_pkg;

    localparam int line_words = 4;

    // word i of the line sits at bits [i*32 +: 32]
    typedef logic [line_words*32-1:0] line_t;

    typedef logic [31:0] addr_t;

    // read request from the cache
    typedef struct packed {
        addr_t addr;
        logic  dma;
    } rd_req_t;

    // evicted dirty line waiting for write back
    typedef struct packed {
        addr_t addr;
        line_t data;
    } wb_entry_t;

    typedef enum logic [2:0] {
        idle   = 3'd0,
        wrt_ar = 3'd1,
        wrt_r  = 3'd2,
        ret_ar = 3'd3,
        ret_r  = 3'd4
    } arb_state_e;

endpackage

`default_nettype wire

// File: l2_mem_read_top.sv
/* wb_depth sets the write-buffer entries (2, 4 or 8)
   the write-back channel is not here, wb_head only exposes the oldest entry */
`timescale 1ns/1ps
`default_nettype none

module l2_mem_read_top #(
    parameter int wb_depth = 4
) (
    input  wire                        clk,
    input  wire                        rstn,
    input  wire                        req,
    input  wire l2_mem_pkg::rd_req_t   req_info,
    input  wire                        rdy,
    input  wire                        wb_push,
    input  wire l2_mem_pkg::wb_entry_t wb_push_entry,
    input  wire                        wb_pop,
    output logic                       addr_ok,
    output logic                       data_ok,
    output l2_mem_pkg::line_t          rd_data,
    output l2_mem_pkg::wb_entry_t      wb_head,
    output logic [$clog2(wb_depth+1)-1:0] wb_count,
    output logic                       wb_full,
    output logic                       mem_req,
    output l2_mem_pkg::addr_t          mem_addr,
    output logic [7:0]                 mem_len,
    input  wire                        mem_addr_ok,
    input  wire                        r_valid,
    input  wire [31:0]                 r_data,
    input  wire                        r_last
);
    logic              query_hit;
    l2_mem_pkg::line_t query_data;
    logic              ret_req;
    logic              ret_done;
    logic              ret_addr_ok;
    logic              ret_data_ok;
    l2_mem_pkg::line_t ret_data;

    write_buffer #(
        .wb_depth (wb_depth)
    ) i_write_buffer (
        .clk        (clk),
        .rstn       (rstn),
        .push       (wb_push),
        .push_entry (wb_push_entry),
        .pop        (wb_pop),
        .query_addr (req_info.addr),
        .query_hit  (query_hit),
        .query_data (query_data),
        .head       (wb_head),
        .count      (wb_count),
        .full       (wb_full)
    );

    read_arbiter i_read_arbiter (
        .clk         (clk),
        .rstn        (rstn),
        .req         (req),
        .req_info    (req_info),
        .rdy         (rdy),
        .query_hit   (query_hit),
        .query_data  (query_data),
        .ret_addr_ok (ret_addr_ok),
        .ret_data_ok (ret_data_ok),
        .ret_data    (ret_data),
        .addr_ok     (addr_ok),
        .data_ok     (data_ok),
        .rd_data     (rd_data),
        .ret_req     (ret_req),
        .ret_done    (ret_done)
    );

    return_buffer i_return_buffer (
        .clk         (clk),
        .rstn        (rstn),
        .ret_req     (ret_req),
        .req_addr    (req_info.addr),
        .ret_done    (ret_done),
        .mem_addr_ok (mem_addr_ok),
        .r_valid     (r_valid),
        .r_data      (r_data),
        .r_last      (r_last),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_len     (mem_len),
        .ret_addr_ok (ret_addr_ok),
        .ret_data_ok (ret_data_ok),
        .ret_data    (ret_data)
    );

endmodule

`default_nettype wire

// File: read_arbiter.sv
/* a buffered line wins over memory unless the request is dma
   req and req_info must stay stable until addr_ok */
`timescale 1ns/1ps
`default_nettype none

module read_arbiter (
    input  wire                      clk,
    input  wire                      rstn,
    input  wire                      req,
    input  wire l2_mem_pkg::rd_req_t req_info,
    input  wire                      rdy,
    input  wire                      query_hit,
    input  wire l2_mem_pkg::line_t   query_data,
    input  wire                      ret_addr_ok,
    input  wire                      ret_data_ok,
    input  wire l2_mem_pkg::line_t   ret_data,
    output logic                     addr_ok,
    output logic                     data_ok,
    output l2_mem_pkg::line_t        rd_data,
    output logic                     ret_req,
    output logic                     ret_done
);
    l2_mem_pkg::arb_state_e state_q;
    l2_mem_pkg::arb_state_e state_d;
    l2_mem_pkg::line_t      hit_line;
    logic                   take_hit;

    assign take_hit = req && query_hit && !req_info.dma;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state_q <= l2_mem_pkg::idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            l2_mem_pkg::idle: begin
                if (take_hit) begin
                    state_d = l2_mem_pkg::wrt_ar;
                end else if (req) begin
                    state_d = l2_mem_pkg::ret_ar;
                end
            end
            l2_mem_pkg::wrt_ar: begin
                state_d = l2_mem_pkg::wrt_r;
            end
            l2_mem_pkg::wrt_r: begin
                if (rdy) begin
                    state_d = l2_mem_pkg::idle;
                end
            end
            l2_mem_pkg::ret_ar: begin
                if (ret_addr_ok) begin
                    state_d = l2_mem_pkg::ret_r;
                end
            end
            l2_mem_pkg::ret_r: begin
                if (ret_data_ok && rdy) begin
                    state_d = l2_mem_pkg::idle;
                end
            end
            default: state_d = l2_mem_pkg::idle;
        endcase
    end

    // write-buffer line captured when the request is taken
    always_ff @(posedge clk) begin
        if ((state_q == l2_mem_pkg::idle) && take_hit) begin
            hit_line <= query_data;
        end
    end

    always_comb begin
        addr_ok  = 1'b0;
        data_ok  = 1'b0;
        rd_data  = '0;
        ret_req  = 1'b0;
        ret_done = 1'b0;
        case (state_q)
            l2_mem_pkg::wrt_ar: begin
                addr_ok = 1'b1;
            end
            l2_mem_pkg::wrt_r: begin
                data_ok = 1'b1;
                rd_data = hit_line;
            end
            l2_mem_pkg::ret_ar: begin
                ret_req = 1'b1;
                addr_ok = ret_addr_ok;
            end
            l2_mem_pkg::ret_r: begin
                data_ok  = ret_data_ok;
                rd_data  = ret_data;
                ret_done = ret_data_ok && rdy;
            end
            default: ;
        endcase
    end

    // no returned line may still be pending once the arbiter is idle
    a_no_data_in_idle: assert property (@(posedge clk) disable iff (!rstn)
        (state_q == l2_mem_pkg::idle) |-> !ret_data_ok);

    // back-pressure holds the line on both paths
    a_hold_until_rdy: assert property (@(posedge clk) disable iff (!rstn)
        (data_ok && !rdy) |=> (data_ok && $stable(rd_data)));

endmodule

`default_nettype wire

// File: return_buffer.sv
/* one outstanding burst of line_words beats, beats are always accepted
   the assembled line holds until ret_done */
`timescale 1ns/1ps
`default_nettype none

module return_buffer (
    input  wire                    clk,
    input  wire                    rstn,
    input  wire                    ret_req,
    input  wire l2_mem_pkg::addr_t req_addr,
    input  wire                    ret_done,
    input  wire                    mem_addr_ok,
    input  wire                    r_valid,
    input  wire [31:0]             r_data,
    input  wire                    r_last,
    output logic                   mem_req,
    output l2_mem_pkg::addr_t      mem_addr,
    output logic [7:0]             mem_len,
    output logic                   ret_addr_ok,
    output logic                   ret_data_ok,
    output l2_mem_pkg::line_t      ret_data
);
    localparam int beat_w = $clog2(l2_mem_pkg::line_words);

    logic              addr_done;
    logic              line_done;
    logic [beat_w-1:0] beat_cnt;
    logic              take_beat;

    // request stays up only until memory takes the address
    assign mem_req     = ret_req && !addr_done;
    assign mem_addr    = req_addr;
    assign mem_len     = 8'(l2_mem_pkg::line_words - 1);
    assign ret_addr_ok = mem_req && mem_addr_ok;
    assign ret_data_ok = line_done;

    // beats only count once the burst is open and the line is not yet complete
    assign take_beat = r_valid && addr_done && !line_done;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            addr_done <= 1'b0;
        end else if (ret_done) begin
            addr_done <= 1'b0;
        end else if (ret_addr_ok) begin
            addr_done <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            beat_cnt <= '0;
        end else if (take_beat) begin
            if (r_last) begin
                beat_cnt <= '0;
            end else begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            line_done <= 1'b0;
        end else if (ret_done) begin
            line_done <= 1'b0;
        end else if (take_beat && r_last) begin
            line_done <= 1'b1;
        end
    end

    // word i of the line comes from beat i
    always_ff @(posedge clk) begin
        if (take_beat) begin
            ret_data[beat_cnt*32 +: 32] <= r_data;
        end
    end

    a_last_on_final_beat: assert property (@(posedge clk) disable iff (!rstn)
        take_beat |-> (r_last == (beat_cnt == beat_w'(l2_mem_pkg::line_words - 1))));

endmodule

`default_nettype wire

// File: tb_l2_mem_read.sv
/* runs with wb_depth 4 and one outstanding read at a time
   memory lines follow the beat rule of tb_mem_model */
`timescale 1ns/1ps
`default_nettype none

module tb_l2_mem_read;
    localparam int          wb_depth = 4;
    localparam int          timeout  = 200;
    localparam logic [31:0] mem_mix  = 32'hc3a5_0f1e;

    typedef logic [$clog2(wb_depth+1)-1:0] count_t;

    logic                  clk;
    logic                  rstn;
    logic                  req;
    l2_mem_pkg::rd_req_t   req_info;
    logic                  rdy;
    logic                  wb_push;
    l2_mem_pkg::wb_entry_t wb_push_entry;
    logic                  wb_pop;
    logic                  addr_ok;
    logic                  data_ok;
    l2_mem_pkg::line_t     rd_data;
    l2_mem_pkg::wb_entry_t wb_head;
    count_t                wb_count;
    logic                  wb_full;
    logic                  mem_req;
    l2_mem_pkg::addr_t     mem_addr;
    logic [7:0]            mem_len;
    logic                  mem_addr_ok;
    logic                  r_valid;
    logic [31:0]           r_data;
    logic                  r_last;

    l2_mem_pkg::wb_entry_t model_q[$];
    l2_mem_pkg::line_t     exp_q[$];
    logic [31:0]           lfsr;
    logic                  held;
    l2_mem_pkg::line_t     held_line;
    int                    hold;

    l2_mem_read_top #(
        .wb_depth (wb_depth)
    ) i_l2_mem_read_top (
        .clk           (clk),
        .rstn          (rstn),
        .req           (req),
        .req_info      (req_info),
        .rdy           (rdy),
        .wb_push       (wb_push),
        .wb_push_entry (wb_push_entry),
        .wb_pop        (wb_pop),
        .addr_ok       (addr_ok),
        .data_ok       (data_ok),
        .rd_data       (rd_data),
        .wb_head       (wb_head),
        .wb_count      (wb_count),
        .wb_full       (wb_full),
        .mem_req       (mem_req),
        .mem_addr      (mem_addr),
        .mem_len       (mem_len),
        .mem_addr_ok   (mem_addr_ok),
        .r_valid       (r_valid),
        .r_data        (r_data),
        .r_last        (r_last)
    );

    tb_mem_model #(
        .word_mix (mem_mix)
    ) i_mem (
        .clk         (clk),
        .rstn        (rstn),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .mem_len     (mem_len),
        .mem_addr_ok (mem_addr_ok),
        .r_valid     (r_valid),
        .r_data      (r_data),
        .r_last      (r_last)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // newest matching buffered line for non-dma reads or the memory line
    function automatic l2_mem_pkg::line_t expected_line(input l2_mem_pkg::addr_t a,
            input logic dma, input l2_mem_pkg::wb_entry_t buf_q[$]);
        l2_mem_pkg::line_t l;
        if (!dma) begin
            for (int k = buf_q.size() - 1; k >= 0; k--) begin
                if (buf_q[k].addr == a) begin
                    return buf_q[k].data;
                end
            end
        end
        for (int i = 0; i < l2_mem_pkg::line_words; i++) begin
            l[i*32 +: 32] = (a + 32'(i)) ^ mem_mix;
        end
        return l;
    endfunction

    function automatic l2_mem_pkg::wb_entry_t make_entry(input l2_mem_pkg::addr_t a,
            input logic [7:0] tag);
        l2_mem_pkg::wb_entry_t e;
        e.addr = a;
        for (int i = 0; i < l2_mem_pkg::line_words; i++) begin
            e.data[i*32 +: 32] = {tag, 8'(i), a[15:0]};
        end
        return e;
    endfunction

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_line(input string name, input l2_mem_pkg::line_t got,
            input l2_mem_pkg::line_t exp);
        if (got !== exp) begin
            stop_run($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_entry(input string name, input l2_mem_pkg::wb_entry_t got,
            input l2_mem_pkg::wb_entry_t exp);
        if (got !== exp) begin
            stop_run($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input count_t got, input count_t exp);
        if (got !== exp) begin
            stop_run($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_run($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input l2_mem_pkg::addr_t got,
            input l2_mem_pkg::addr_t exp);
        if (got !== exp) begin
            stop_run($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_len(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic rand_hold(output int n);
        n = 0;
        for (int b = 0; b < 3; b++) begin
            lfsr = lfsr_next(lfsr);
            n = n * 2 + lfsr[0];
        end
        n = n + 1;
    endtask

    task automatic push_line(input l2_mem_pkg::wb_entry_t e);
        @(posedge clk);
        wb_push       <= 1'b1;
        wb_push_entry <= e;
        @(posedge clk);
        wb_push <= 1'b0;
        if (model_q.size() < wb_depth) begin
            model_q.push_back(e);
        end
    endtask

    task automatic pop_head();
        @(posedge clk);
        check_entry("wb_head", wb_head, model_q[0]);
        wb_pop <= 1'b1;
        @(posedge clk);
        wb_pop <= 1'b0;
        void'(model_q.pop_front());
    endtask

    // hit path has fixed timing while the miss path waits on memory
    task automatic do_read(input l2_mem_pkg::addr_t a, input logic dma, input int hold_cyc,
            input logic hit);
        int t;
        exp_q.push_back(expected_line(a, dma, model_q));
        @(posedge clk);
        req           <= 1'b1;
        req_info.addr <= a;
        req_info.dma  <= dma;
        rdy           <= (hold_cyc == 0);
        if (hit) begin
            @(posedge clk);
            check_flag("addr_ok", addr_ok, 1'b0);
            @(posedge clk);
            check_flag("addr_ok", addr_ok, 1'b1);
            req <= 1'b0;
            @(posedge clk);
            check_flag("data_ok", data_ok, 1'b1);
            check_flag("addr_ok", addr_ok, 1'b0);
        end else begin
            @(posedge clk);
            check_flag("mem_req", mem_req, 1'b0);
            @(posedge clk);
            check_flag("mem_req", mem_req, 1'b1);
            check_addr("mem_addr", mem_addr, a);
            check_len("mem_len", mem_len, 8'd3);
            t = 0;
            do begin
                @(posedge clk);
                t++;
                if (t > timeout) stop_run("timeout waiting for addr_ok");
                check_flag("addr_ok", addr_ok, mem_addr_ok);
            end while (!addr_ok);
            req <= 1'b0;
            t = 0;
            do begin
                @(posedge clk);
                t++;
                if (t > timeout) stop_run("timeout waiting for data_ok");
            end while (!data_ok);
        end
        if (hold_cyc > 0) begin
            repeat (hold_cyc) @(posedge clk);
            rdy <= 1'b1;
        end
        t = 0;
        while (data_ok) begin
            @(posedge clk);
            t++;
            if (t > timeout) stop_run("timeout waiting for data_ok to fall");
        end
    endtask

    // compares each delivered line and watches the line under back-pressure
    always @(posedge clk) begin
        if (rstn) begin
            if (held) begin
                check_flag("data_ok", data_ok, 1'b1);
                check_line("rd_data", rd_data, held_line);
            end
            if (data_ok && rdy) begin
                if (exp_q.size() == 0) stop_run("data_ok seen with no read pending");
                check_line("rd_data", rd_data, exp_q.pop_front());
            end
            held      = data_ok && !rdy;
            held_line = rd_data;
        end
    end

    initial begin
        clk           = 1'b0;
        rstn          = 1'b0;
        req           = 1'b0;
        req_info      = '0;
        rdy           = 1'b0;
        wb_push       = 1'b0;
        wb_push_entry = '0;
        wb_pop        = 1'b0;
        held          = 1'b0;
        held_line     = '0;
        lfsr          = 32'hea65031d;
        repeat (10) @(posedge clk);
        check_flag("addr_ok", addr_ok, 1'b0);
        check_flag("data_ok", data_ok, 1'b0);
        check_flag("mem_req", mem_req, 1'b0);
        check_flag("wb_full", wb_full, 1'b0);
        check_count("wb_count", wb_count, '0);
        rstn <= 1'b1;

        push_line(make_entry(32'h0000_1000, 8'ha1));
        do_read(32'h0000_1000, 1'b0, 0, 1'b1);
        do_read(32'h0000_2000, 1'b0, 0, 1'b0);
        push_line(make_entry(32'h0000_3000, 8'hb1));
        push_line(make_entry(32'h0000_3000, 8'hb2));
        do_read(32'h0000_3000, 1'b0, 0, 1'b1);
        do_read(32'h0000_1000, 1'b1, 0, 1'b0);
        rand_hold(hold);
        do_read(32'h0000_1000, 1'b0, hold, 1'b1);
        rand_hold(hold);
        do_read(32'h0000_4000, 1'b0, hold, 1'b0);

        // drain and then overfill by one
        while (model_q.size() > 0) pop_head();
        @(posedge clk);
        check_count("wb_count", wb_count, '0);
        for (int i = 0; i < 5; i++) begin
            push_line(make_entry(32'h0000_5000 + 32'(i * 16), 8'(8'hc0 + i)));
        end
        @(posedge clk);
        check_flag("wb_full", wb_full, 1'b1);
        check_count("wb_count", wb_count, count_t'(wb_depth));
        while (model_q.size() > 0) pop_head();
        @(posedge clk);
        check_count("wb_count", wb_count, '0);
        check_flag("wb_full", wb_full, 1'b0);

        if (exp_q.size() == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            stop_run("reads finished without delivering their lines");
        end
    end

endmodule

`default_nettype wire

// File: tb_mem_model.sv
/* memory responder for one burst at a time, 1 to 8 random cycles before the address
   is taken and before each beat; beat i of address a is (a + i) xor word_mix */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model #(
    parameter logic [31:0] word_mix = 32'h0
) (
    input  wire                    clk,
    input  wire                    rstn,
    input  wire                    mem_req,
    input  wire l2_mem_pkg::addr_t mem_addr,
    input  wire [7:0]              mem_len,
    output logic                   mem_addr_ok,
    output logic                   r_valid,
    output logic [31:0]            r_data,
    output logic                   r_last
);
    logic [31:0] lfsr;

    // fibonacci taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_gap();
        int n;
        n = 0;
        for (int b = 0; b < 3; b++) begin
            lfsr = lfsr_next(lfsr);
            n = n * 2 + lfsr[0];
        end
        repeat (n + 1) @(posedge clk);
    endtask

    initial begin
        lfsr        = 32'hea65031d;
        mem_addr_ok = 1'b0;
        r_valid     = 1'b0;
        r_data      = '0;
        r_last      = 1'b0;
    end

    always begin : serve
        l2_mem_pkg::addr_t base;
        @(posedge clk);
        if (rstn && mem_req) begin
            base = mem_addr;
            random_gap();
            mem_addr_ok <= 1'b1;
            @(posedge clk);
            mem_addr_ok <= 1'b0;
            for (int i = 0; i <= int'(mem_len); i++) begin
                random_gap();
                r_valid <= 1'b1;
                r_data  <= (base + 32'(i)) ^ word_mix;
                r_last  <= (i == int'(mem_len));
                @(posedge clk);
                r_valid <= 1'b0;
                r_last  <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: write_buffer.sv
/* push while full is dropped and pop while empty is ignored
   wb_depth must be at least 2 */
`timescale 1ns/1ps
`default_nettype none

module write_buffer #(
    parameter int wb_depth = 4
) (
    input  wire                        clk,
    input  wire                        rstn,
    input  wire                        push,
    input  wire l2_mem_pkg::wb_entry_t push_entry,
    input  wire                        pop,
    input  wire l2_mem_pkg::addr_t     query_addr,
    output logic                       query_hit,
    output l2_mem_pkg::line_t          query_data,
    output l2_mem_pkg::wb_entry_t      head,
    output logic [$clog2(wb_depth+1)-1:0] count,
    output logic                       full
);
    localparam int ptr_w = $clog2(wb_depth);
    localparam int cnt_w = $clog2(wb_depth + 1);

    l2_mem_pkg::wb_entry_t entries [wb_depth];
    logic [wb_depth-1:0]   valid;
    logic [ptr_w-1:0]      head_ptr;
    logic [ptr_w-1:0]      tail_ptr;
    logic                  do_push;
    logic                  do_pop;

    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        if (ptr == ptr_w'(wb_depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full    = (count == cnt_w'(wb_depth));
    assign do_push = push && !full;
    assign do_pop  = pop && (count != '0);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid    <= '0;
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            if (do_push) begin
                valid[tail_ptr] <= 1'b1;
                tail_ptr        <= next_ptr(tail_ptr);
            end
            if (do_pop) begin
                valid[head_ptr] <= 1'b0;
                head_ptr        <= next_ptr(head_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            entries[tail_ptr] <= push_entry;
        end
    end

    // walk from oldest to youngest so the last match wins
    always_comb begin
        logic [ptr_w-1:0] idx;
        query_hit  = 1'b0;
        query_data = '0;
        idx        = head_ptr;
        for (int k = 0; k < wb_depth; k++) begin
            if (valid[idx] && (entries[idx].addr == query_addr)) begin
                query_hit  = 1'b1;
                query_data = entries[idx].data;
            end
            idx = next_ptr(idx);
        end
    end

    assign head = valid[head_ptr] ? entries[head_ptr] : '0;

    // count stays in range and agrees with the valid bits
    a_count_bound: assert property (@(posedge clk) disable iff (!rstn)
        (count <= cnt_w'(wb_depth)) && (count == cnt_w'($countones(valid))));

endmodule

`default_nettype wire
